// ==== hw/stream_arb_cfg.svh ====
// Build-time configuration for the stream arbiter.
// Include this header wherever the input count, widths or APB register
// offsets are needed. Override the values here to resize the design.

`ifndef STREAM_ARB_CFG_SVH
`define STREAM_ARB_CFG_SVH

// Number of request streams merged onto the shared port
`define STREAM_ARB_NUM_INPUTS 4

// Payload width of each stream word
`define STREAM_ARB_DATA_WIDTH 32

// Width of each saturating transfer counter
`define STREAM_ARB_COUNT_WIDTH 16

// APB byte offsets, counter i sits at COUNT_BASE + 4*i
`define STREAM_ARB_REG_CTRL 12'h000
`define STREAM_ARB_REG_ENABLE 12'h004
`define STREAM_ARB_REG_COUNT_BASE 12'h008

`endif

// ==== hw/stream_arb_pkg.sv ====
// Shared types for the stream arbiter RTL and its testbench.
// Refer to the types by scoped name, for example stream_arb_pkg::grant_t.

`default_nettype none

`include "stream_arb_cfg.svh"

package stream_arb_pkg;

    // Index width, kept at one bit or more so a single input still compiles
    localparam int SOURCE_WIDTH = (`STREAM_ARB_NUM_INPUTS > 1) ?
                                  $clog2(`STREAM_ARB_NUM_INPUTS) : 1;

    typedef logic [`STREAM_ARB_DATA_WIDTH-1:0]  data_t;
    typedef logic [`STREAM_ARB_NUM_INPUTS-1:0]  grant_t;
    typedef logic [SOURCE_WIDTH-1:0]            source_t;
    typedef logic [`STREAM_ARB_COUNT_WIDTH-1:0] count_t;

    // 0 is fixed priority with the lowest index winning, 1 is round robin
    typedef logic mode_t;

    typedef logic [11:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

endpackage

`default_nettype wire

// ==== hw/onehot_mux.sv ====
// Generic one-hot multiplexer.
// Steers the word whose select bit is set to the output. The select vector
// must be one-hot or zero; with no bit set the output is zero.

`timescale 1ns/100ps
`default_nettype none

module onehot_mux #(
    parameter int DATAW = 1,
    parameter int N     = 1
) (
    input  wire [N-1:0][DATAW-1:0] data_in,
    input  wire [N-1:0]            sel_in,
    output logic [DATAW-1:0]       data_out
);

    if (N == 1) begin : g_single
        // A lone word still honours its select bit
        assign data_out = data_in[0] & {DATAW{sel_in[0]}};
    end else begin : g_and_or
        logic [N-1:0][DATAW-1:0] masked;

        // Zero every word whose select bit is low
        for (genvar i = 0; i < N; i++) begin : g_mask
            assign masked[i] = data_in[i] & {DATAW{sel_in[i]}};
        end

        // OR the masked words together one output bit at a time
        for (genvar b = 0; b < DATAW; b++) begin : g_bit
            logic [N-1:0] gather;

            for (genvar j = 0; j < N; j++) begin : g_gather
                assign gather[j] = masked[j][b];
            end

            assign data_out[b] = |gather;
        end
    end

endmodule

`default_nettype wire

// ==== hw/grant_arbiter.sv ====
// Grant arbiter for the stream merger.
// Picks one enabled, valid input by fixed priority or round robin and
// presents a one-hot grant plus its index. Under back-pressure the grant
// is held until the transfer completes.

`timescale 1ns/100ps
`default_nettype none

`include "stream_arb_cfg.svh"

module grant_arbiter (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire stream_arb_pkg::grant_t    in_valid,
    input  wire stream_arb_pkg::grant_t    enable,
    input  wire stream_arb_pkg::mode_t     mode,
    input  wire                            out_ready,
    output stream_arb_pkg::grant_t         grant,
    output stream_arb_pkg::source_t        source,
    output logic                           out_valid
);

    localparam int N = `STREAM_ARB_NUM_INPUTS;

    stream_arb_pkg::grant_t  eligible;
    stream_arb_pkg::grant_t  fixed_grant;
    stream_arb_pkg::grant_t  rr_grant;
    stream_arb_pkg::grant_t  held_grant;
    stream_arb_pkg::source_t rr_ptr;
    logic                    locked;
    logic                    transfer;

    assign eligible = in_valid & enable;

    // Two's complement trick isolates the lowest set bit
    assign fixed_grant = eligible & (~eligible + 1'b1);

    // First eligible input at or after the pointer, wrapping past N-1
    always_comb begin
        int   idx;
        logic found;

        rr_grant = '0;
        found    = 1'b0;
        for (int off = 0; off < N; off++) begin
            idx = int'(rr_ptr) + off;
            if (idx >= N) begin
                idx = idx - N;
            end
            if (!found && eligible[idx]) begin
                rr_grant[idx] = 1'b1;
                found         = 1'b1;
            end
        end
    end

    // A locked input keeps its grant even if a better candidate shows up
    assign grant = locked ? held_grant : (mode ? rr_grant : fixed_grant);

    // The locked source keeps valid high by the stream rule, so the output
    // stays valid through an enable change
    assign out_valid = locked | (|eligible);
    assign transfer  = out_valid & out_ready;

    always_comb begin
        source = '0;
        for (int i = 0; i < N; i++) begin
            if (grant[i]) begin
                source = source | stream_arb_pkg::source_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            locked <= 1'b0;
            rr_ptr <= '0;
        end else begin
            locked <= out_valid & ~out_ready;
            if (transfer) begin
                rr_ptr <= (source == stream_arb_pkg::source_t'(N - 1)) ? '0 : source + 1'b1;
            end
        end
    end

    // Only read back while locked is set
    always_ff @(posedge clk) begin
        held_grant <= grant;
    end

endmodule

`default_nettype wire

// ==== hw/arb_regs.sv ====
// APB register block for the stream arbiter.
// CTRL bit 0 selects the arbitration mode, ENABLE masks inputs, and one
// saturating counter per input tracks completed transfers. A write of any
// value to a counter clears it. No wait states; unmapped accesses error.

`timescale 1ns/100ps
`default_nettype none

`include "stream_arb_cfg.svh"

module arb_regs (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            psel,
    input  wire                            penable,
    input  wire                            pwrite,
    input  wire stream_arb_pkg::apb_addr_t paddr,
    input  wire stream_arb_pkg::apb_data_t pwdata,
    output stream_arb_pkg::apb_data_t      prdata,
    output logic                           pready,
    output logic                           pslverr,
    input  wire stream_arb_pkg::grant_t    grant,
    input  wire stream_arb_pkg::grant_t    in_valid,
    input  wire                            out_ready,
    output stream_arb_pkg::mode_t          mode,
    output stream_arb_pkg::grant_t         enable
);

    localparam int N = `STREAM_ARB_NUM_INPUTS;

    stream_arb_pkg::count_t counts [N];
    stream_arb_pkg::grant_t count_hit;
    stream_arb_pkg::grant_t count_inc;
    logic                   hit_ctrl;
    logic                   hit_enable;
    logic                   mapped;
    logic                   access;
    logic                   wr_en;

    assign access = psel & penable;
    assign wr_en  = access & pwrite;

    always_comb begin
        hit_ctrl   = (paddr == `STREAM_ARB_REG_CTRL);
        hit_enable = (paddr == `STREAM_ARB_REG_ENABLE);
        for (int i = 0; i < N; i++) begin
            count_hit[i] = (paddr == stream_arb_pkg::apb_addr_t'(
                            `STREAM_ARB_REG_COUNT_BASE + 4 * i));
        end
    end

    assign mapped  = hit_ctrl | hit_enable | (|count_hit);
    assign pready  = 1'b1;
    assign pslverr = access & ~mapped;

    // Read mux returns zero for anything unmapped
    always_comb begin
        prdata = '0;
        if (hit_ctrl) begin
            prdata = stream_arb_pkg::apb_data_t'(mode);
        end else if (hit_enable) begin
            prdata = stream_arb_pkg::apb_data_t'(enable);
        end
        for (int i = 0; i < N; i++) begin
            if (count_hit[i]) begin
                prdata = stream_arb_pkg::apb_data_t'(counts[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mode   <= 1'b0;
            enable <= '1;
        end else if (wr_en) begin
            if (hit_ctrl) begin
                mode <= pwdata[0];
            end
            if (hit_enable) begin
                enable <= pwdata[N-1:0];
            end
        end
    end

    // An input completes a transfer when it holds the grant and both
    // sides of the handshake are high
    assign count_inc = grant & in_valid & {N{out_ready}};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < N; i++) begin
                counts[i] <= '0;
            end
        end else begin
            for (int i = 0; i < N; i++) begin
                if (wr_en && count_hit[i]) begin
                    counts[i] <= '0;
                end else if (count_inc[i] && (counts[i] != '1)) begin
                    counts[i] <= counts[i] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/stream_arb_top.sv ====
// Top level of the N-input stream arbiter.
// Merges several valid/ready request streams onto one output port. The
// output path is combinational; an APB slave sets mode and enable mask and
// exposes per-input transfer counters.

`timescale 1ns/100ps
`default_nettype none

`include "stream_arb_cfg.svh"

module stream_arb_top (
    input  wire                                   clk,
    input  wire                                   rst_n,
    // Input streams
    input  wire stream_arb_pkg::grant_t           in_valid,
    input  wire stream_arb_pkg::data_t [`STREAM_ARB_NUM_INPUTS-1:0] in_data,
    output stream_arb_pkg::grant_t                in_ready,
    // Merged output stream
    output logic                                  out_valid,
    output stream_arb_pkg::data_t                 out_data,
    output stream_arb_pkg::source_t               out_source,
    input  wire                                   out_ready,
    // APB slave
    input  wire                                   psel,
    input  wire                                   penable,
    input  wire                                   pwrite,
    input  wire stream_arb_pkg::apb_addr_t        paddr,
    input  wire stream_arb_pkg::apb_data_t        pwdata,
    output stream_arb_pkg::apb_data_t             prdata,
    output logic                                  pready,
    output logic                                  pslverr
);

    stream_arb_pkg::grant_t grant;
    stream_arb_pkg::grant_t enable;
    stream_arb_pkg::mode_t  mode;

    grant_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .enable    (enable),
        .mode      (mode),
        .out_ready (out_ready),
        .grant     (grant),
        .source    (out_source),
        .out_valid (out_valid)
    );

    onehot_mux #(
        .DATAW (`STREAM_ARB_DATA_WIDTH),
        .N     (`STREAM_ARB_NUM_INPUTS)
    ) u_mux (
        .data_in  (in_data),
        .sel_in   (grant),
        .data_out (out_data)
    );

    arb_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .grant     (grant),
        .in_valid  (in_valid),
        .out_ready (out_ready),
        .mode      (mode),
        .enable    (enable)
    );

    // Only the granted input sees the downstream ready
    assign in_ready = grant & {`STREAM_ARB_NUM_INPUTS{out_ready}};

endmodule

`default_nettype wire

// ==== tb/stream_arb_tb.sv ====
// Directed testbench for the stream arbiter top level.
// Drives the input streams and the APB port from tasks, checks the merged
// output against the expected grant and prints a closing summary line.

`timescale 1ns/100ps
`default_nettype none

`include "stream_arb_cfg.svh"

module stream_arb_tb;

    localparam int N = `STREAM_ARB_NUM_INPUTS;
    // Cycle budget of reset and of each test in the order they run
    localparam int TOTAL_CYCLES = 5 + 25 + 25 + 35 + 15 + 25 + 60;

    logic                          clk;
    logic                          rst_n;
    stream_arb_pkg::grant_t        in_valid;
    stream_arb_pkg::data_t [N-1:0] in_data;
    stream_arb_pkg::grant_t        in_ready;
    logic                          out_valid;
    stream_arb_pkg::data_t         out_data;
    stream_arb_pkg::source_t       out_source;
    logic                          out_ready;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    stream_arb_pkg::apb_addr_t     paddr;
    stream_arb_pkg::apb_data_t     pwdata;
    stream_arb_pkg::apb_data_t     prdata;
    logic                          pready;
    logic                          pslverr;

    // Words currently offered by each source and replaced after each transfer
    stream_arb_pkg::data_t [N-1:0] words;
    stream_arb_pkg::source_t       last_src;
    logic                          apb_err;
    int                            errors;

    stream_arb_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(TOTAL_CYCLES * 20 + 2000);
        $display("Watchdog expired at %0t, the tests did not finish", $time);
        $display("TEST FAILED");
        $finish;
    end

    // First set bit after position last when wrapping around
    function automatic stream_arb_pkg::source_t next_after(input stream_arb_pkg::grant_t v,
                                                           input stream_arb_pkg::source_t last);
        int idx;
        for (int off = 1; off <= N; off++) begin
            idx = (int'(last) + off) % N;
            if (v[idx]) begin
                return stream_arb_pkg::source_t'(idx);
            end
        end
        return '0;
    endfunction

    function automatic stream_arb_pkg::apb_addr_t count_addr(input int i);
        return stream_arb_pkg::apb_addr_t'(`STREAM_ARB_REG_COUNT_BASE + 4 * i);
    endfunction

    task automatic check_data(input string name, input stream_arb_pkg::data_t exp,
                              input stream_arb_pkg::data_t act);
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_source(input string name, input stream_arb_pkg::source_t exp,
                                input stream_arb_pkg::source_t act);
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input stream_arb_pkg::count_t exp,
                               input stream_arb_pkg::count_t act);
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_bits(input string name, input stream_arb_pkg::grant_t exp,
                              input stream_arb_pkg::grant_t act);
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input stream_arb_pkg::apb_data_t exp,
                              input stream_arb_pkg::apb_data_t act);
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic apb_write(input stream_arb_pkg::apb_addr_t addr,
                             input stream_arb_pkg::apb_data_t data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        apb_err = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input stream_arb_pkg::apb_addr_t addr,
                            output stream_arb_pkg::apb_data_t data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data    = prdata;
        apb_err = pslverr;
        check_flag("pready", 1'b1, pready);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // One stream cycle where exp_src is only checked when exp_valid is set
    task automatic send_cycle(input stream_arb_pkg::grant_t valid, input logic ready,
                              input logic exp_valid, input stream_arb_pkg::source_t exp_src);
        stream_arb_pkg::grant_t exp_ready;
        @(posedge clk);
        in_valid  <= valid;
        in_data   <= words;
        out_ready <= ready;
        @(negedge clk);
        exp_ready = (exp_valid && ready) ? (stream_arb_pkg::grant_t'(1) << exp_src) : '0;
        check_flag("out_valid", exp_valid, out_valid);
        check_bits("in_ready", exp_ready, in_ready);
        if (exp_valid) begin
            check_source("out_source", exp_src, out_source);
            check_data("out_data", words[exp_src], out_data);
            if (ready) begin
                words[exp_src] = stream_arb_pkg::data_t'($urandom);
                last_src = exp_src;
            end
        end
    endtask

    // Serve every pending request with out_ready high and then go idle
    task automatic drain(input stream_arb_pkg::grant_t pending, input logic rr);
        stream_arb_pkg::source_t exp;
        while (pending != '0) begin
            exp = rr ? next_after(pending, last_src) :
                       next_after(pending, stream_arb_pkg::source_t'(N - 1));
            send_cycle(pending, 1'b1, 1'b1, exp);
            pending[exp] = 1'b0;
        end
        send_cycle('0, 1'b0, 1'b0, '0);
    endtask

    task automatic test_reset_regs();
        stream_arb_pkg::apb_data_t rd;
        apb_read(`STREAM_ARB_REG_CTRL, rd);
        check_word("ctrl", '0, rd);
        check_flag("pslverr", 1'b0, apb_err);
        apb_read(`STREAM_ARB_REG_ENABLE, rd);
        check_bits("enable", '1, stream_arb_pkg::grant_t'(rd));
        for (int i = 0; i < N; i++) begin
            apb_read(count_addr(i), rd);
            check_count($sformatf("count[%0d]", i), '0, stream_arb_pkg::count_t'(rd));
        end
        apb_read(12'h100, rd);
        check_word("unmapped prdata", '0, rd);
        check_flag("pslverr", 1'b1, apb_err);
        apb_write(12'h0fc, 32'h1234_5678);
        check_flag("pslverr", 1'b1, apb_err);
        send_cycle('0, 1'b0, 1'b0, '0);
    endtask

    task automatic test_fixed_priority();
        stream_arb_pkg::grant_t  pending;
        stream_arb_pkg::source_t exp;
        pending = '0;
        for (int i = 0; i < 8; i++) begin
            pending = pending | stream_arb_pkg::grant_t'($urandom);
            pending[$urandom % N] = 1'b1;
            exp = next_after(pending, stream_arb_pkg::source_t'(N - 1));
            // Held off once, so in_ready must stay low while the grant shows
            send_cycle(pending, 1'b0, 1'b1, exp);
            send_cycle(pending, 1'b1, 1'b1, exp);
            pending[exp] = 1'b0;
        end
        drain(pending, 1'b0);
    endtask

    task automatic test_round_robin();
        stream_arb_pkg::grant_t  pending;
        stream_arb_pkg::source_t exp;
        apb_write(`STREAM_ARB_REG_CTRL, 32'h1);
        for (int i = 0; i < 2 * N; i++) begin
            exp = next_after('1, last_src);
            send_cycle('1, 1'b1, 1'b1, exp);
        end
        pending = '0;
        for (int i = 0; i < 12; i++) begin
            pending = pending | (stream_arb_pkg::grant_t'($urandom) &
                                 stream_arb_pkg::grant_t'($urandom));
            pending[$urandom % N] = 1'b1;
            exp = next_after(pending, last_src);
            send_cycle(pending, 1'b1, 1'b1, exp);
            pending[exp] = 1'b0;
        end
        drain(pending, 1'b1);
    endtask

    task automatic test_backpressure();
        apb_write(`STREAM_ARB_REG_CTRL, 32'h0);
        send_cycle(4'b0100, 1'b0, 1'b1, 2);
        // Input 0 would win on priority but the lock keeps input 2
        send_cycle(4'b0101, 1'b0, 1'b1, 2);
        send_cycle(4'b0101, 1'b0, 1'b1, 2);
        send_cycle(4'b0101, 1'b1, 1'b1, 2);
        send_cycle(4'b0001, 1'b1, 1'b1, 0);
        send_cycle('0, 1'b0, 1'b0, '0);
    endtask

    task automatic test_enable_mask();
        apb_write(`STREAM_ARB_REG_ENABLE, 32'h0000_000b);
        send_cycle(4'b0101, 1'b1, 1'b1, 0);
        send_cycle(4'b0100, 1'b1, 1'b0, '0);
        send_cycle(4'b1100, 1'b1, 1'b1, 3);
        send_cycle(4'b0100, 1'b1, 1'b0, '0);
        send_cycle(4'b0100, 1'b0, 1'b0, '0);
        apb_write(`STREAM_ARB_REG_ENABLE, 32'h0000_000f);
        send_cycle(4'b0100, 1'b1, 1'b1, 2);
        send_cycle('0, 1'b0, 1'b0, '0);
    endtask

    task automatic test_counters();
        stream_arb_pkg::apb_data_t rd;
        for (int i = 0; i < N; i++) begin
            apb_write(count_addr(i), 32'hffff_ffff);
        end
        // Input i completes i+1 transfers
        for (int i = 0; i < N; i++) begin
            repeat (i + 1) begin
                send_cycle(stream_arb_pkg::grant_t'(1) << i, 1'b1, 1'b1, i);
            end
        end
        send_cycle('0, 1'b0, 1'b0, '0);
        for (int i = 0; i < N; i++) begin
            apb_read(count_addr(i), rd);
            check_count($sformatf("count[%0d]", i), i + 1, stream_arb_pkg::count_t'(rd));
        end
        apb_write(count_addr(1), 32'h0);
        for (int i = 0; i < N; i++) begin
            apb_read(count_addr(i), rd);
            check_count($sformatf("count[%0d]", i), (i == 1) ? 0 : i + 1,
                        stream_arb_pkg::count_t'(rd));
        end
    endtask

    initial begin
        void'($urandom(14373));
        errors   = 0;
        last_src = stream_arb_pkg::source_t'(N - 1);
        for (int i = 0; i < N; i++) begin
            words[i] = stream_arb_pkg::data_t'($urandom);
        end
        rst_n     <= 1'b0;
        in_valid  <= '0;
        in_data   <= '0;
        out_ready <= 1'b0;
        psel      <= 1'b0;
        penable   <= 1'b0;
        pwrite    <= 1'b0;
        paddr     <= '0;
        pwdata    <= '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_regs();
        test_fixed_priority();
        test_round_robin();
        test_backpressure();
        test_enable_mask();
        test_counters();
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== stream_arb.f ====
+incdir+hw
hw/stream_arb_pkg.sv
hw/onehot_mux.sv
hw/grant_arbiter.sv
hw/arb_regs.sv
hw/stream_arb_top.sv
tb/stream_arb_tb.sv
